// File: Bender.yml
package:
  name: elev_pixel

sources:
  - elev_geom_pkg.sv
  - elev_color_pkg.sv
  - region_classify.sv
  - car_locate.sv
  - palette_map.sv
  - elev_pixel_pipe.sv
  - target: test
    files:
      - elev_pixel_assert.sv
      - tb_elev_pixel.sv

// File: car_locate.sv
`timescale 1ns/1ns
`default_nettype none

module car_locate (
    input  logic                        clk,
    input  logic                        rst_n,
    input  elev_geom_pkg::region_t      region,
    input  logic                        floor_odd,
    input  elev_geom_pkg::coord_t       x_q,
    input  elev_geom_pkg::coord_t       y_q,
    input  logic                        valid_in,
    input  elev_geom_pkg::sim_state_t   sim_state,
    input  logic [7:0]                  destination,
    output elev_color_pkg::pix_class_t  pix_class,
    output logic                        valid
);
    import elev_geom_pkg::*;
    import elev_color_pkg::*;

    level_t     level;
    coord_t     car_top;
    logic       in_idle_car;
    logic       in_moving_car;
    logic       in_stop_mark;
    pix_class_t shaft_class;
    pix_class_t class_d;

    // Upper nibble drives the left car
    always_comb begin
        if (region == reg_shaft_left) begin
            level = destination[7:4];
        end else begin
            level = destination[3:0];
        end
        if (level > level_t'(max_level)) begin
            level = level_t'(max_level);
        end
        car_top = car_top_lut[level];
    end

    assign in_idle_car = y_q >= max_vert - top_bottom_buffer - elevator_height;
    assign in_moving_car = (y_q >= car_top) && (y_q < car_top + car_height);
    assign in_stop_mark = (x_q >= stop_x_lo) && (x_q < stop_x_hi)
        && (y_q >= stop_y_lo) && (y_q < stop_y_hi);

    always_comb begin
        case (sim_state)
            sim_idle:   shaft_class = in_idle_car ? pc_car : pc_shaft_bg;
            sim_moving: shaft_class = in_moving_car ? pc_car : pc_shaft_bg;
            // Both remaining codes mean stop
            default:    shaft_class = in_stop_mark ? pc_stop_mark : pc_stop_bg;
        endcase
    end

    always_comb begin
        case (region)
            reg_sky:         class_d = pc_sky;
            reg_building:    class_d = floor_odd ? pc_floor_b : pc_floor_a;
            reg_outline:     class_d = pc_outline;
            reg_shaft_left:  class_d = shaft_class;
            reg_shaft_right: class_d = shaft_class;
            default:         class_d = pc_grass;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            pix_class <= pc_blank;
        end else begin
            valid     <= valid_in;
            pix_class <= valid_in ? class_d : pc_blank;
        end
    end

endmodule

`default_nettype wire

// File: elev_color_pkg.sv
package elev_color_pkg;

    typedef logic [3:0] channel_t;

    typedef enum logic [3:0] {
        pc_blank,
        pc_sky,
        pc_floor_a,
        pc_floor_b,
        pc_outline,
        pc_shaft_bg,
        pc_car,
        pc_stop_bg,
        pc_stop_mark,
        pc_grass
    } pix_class_t;

    localparam channel_t sky_r = 4'd2;
    localparam channel_t sky_g = 4'd8;
    localparam channel_t sky_b = 4'd15;

    // Two greys for alternating floors
    localparam channel_t floor_a_r = 4'd9;
    localparam channel_t floor_a_g = 4'd10;
    localparam channel_t floor_a_b = 4'd10;
    localparam channel_t floor_b_r = 4'd11;
    localparam channel_t floor_b_g = 4'd11;
    localparam channel_t floor_b_b = 4'd11;

    localparam channel_t outline_r = 4'd0;
    localparam channel_t outline_g = 4'd0;
    localparam channel_t outline_b = 4'd0;
    localparam channel_t shaft_bg_r = 4'd8;
    localparam channel_t shaft_bg_g = 4'd4;
    localparam channel_t shaft_bg_b = 4'd1;
    localparam channel_t car_r = 4'd4;
    localparam channel_t car_g = 4'd4;
    localparam channel_t car_b = 4'd4;

    localparam channel_t stop_bg_r = 4'd0;
    localparam channel_t stop_bg_g = 4'd0;
    localparam channel_t stop_bg_b = 4'd0;
    localparam channel_t stop_mark_r = 4'd15;
    localparam channel_t stop_mark_g = 4'd0;
    localparam channel_t stop_mark_b = 4'd0;

    localparam channel_t grass_r = 4'd0;
    localparam channel_t grass_g = 4'd15;
    localparam channel_t grass_b = 4'd0;
    localparam channel_t blank_r = 4'd0;
    localparam channel_t blank_g = 4'd0;
    localparam channel_t blank_b = 4'd0;

endpackage

// File: elev_geom_pkg.sv
package elev_geom_pkg;

    typedef logic [9:0] coord_t;

    // Half-floor steps, 0 is floor 1 and 10 is floor 6
    typedef logic [3:0] level_t;

    typedef logic [1:0] sim_state_t;

    typedef enum logic [2:0] {
        reg_sky,
        reg_building,
        reg_outline,
        reg_shaft_left,
        reg_shaft_right,
        reg_grass
    } region_t;

    // Screen size
    localparam int max_horiz = 640;
    localparam int max_vert = 480;

    // Border of sky and grass around the scene
    localparam int side_buffer = 20;
    localparam int top_bottom_buffer = 15;

    localparam int floor_width = 75;
    localparam int car_height = 75;
    // Idle car only shows 70 rows above the grass line
    localparam int elevator_height = 70;

    // Column boundaries, each end is exclusive
    localparam int building_left_end = 195;
    localparam int shaft_left_start = 205;
    localparam int shaft_left_end = 295;
    localparam int shaft_right_start = 305;
    localparam int shaft_right_end = 395;
    localparam int building_right_start = 405;

    // Red marker box in the stop state
    localparam int stop_x_lo = 300;
    localparam int stop_x_hi = 340;
    localparam int stop_y_lo = 200;
    localparam int stop_y_hi = 260;

    localparam sim_state_t sim_idle = 2'd0;
    localparam sim_state_t sim_moving = 2'd1;

    localparam int max_level = 10;

    // Top row of the car per level, 390 - floor(75 * level / 2)
    localparam coord_t car_top_lut [0:max_level] = '{
        10'd390, 10'd353, 10'd315, 10'd278,
        10'd240, 10'd203, 10'd165, 10'd128,
        10'd90, 10'd53, 10'd15
    };

endpackage

// File: elev_pixel_assert.sv
`timescale 1ns/1ns

module elev_pixel_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       enable,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);
    int failures = 0;

    // A pixel entered with enable low leaves the pipe black
    property blank_when_disabled;
        @(posedge clk) disable iff (!rst_n)
        !enable |-> ##3 ({red, green, blue} == 12'h000);
    endproperty

    property dark_in_reset;
        @(negedge clk) !rst_n |-> ({red, green, blue} == 12'h000);
    endproperty

    blank_check: assert property (blank_when_disabled) else begin
        failures++;
        $error("Colour not zero three cycles after a disabled pixel");
    end

    reset_check: assert property (dark_in_reset) else begin
        failures++;
        $error("Colour not zero while reset is held");
    end

endmodule

bind elev_pixel_pipe elev_pixel_assert pipe_checks_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (enable),
    .red    (red),
    .green  (green),
    .blue   (blue)
);

// File: elev_pixel_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module elev_pixel_pipe (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  elev_geom_pkg::coord_t     x_coord,
    input  elev_geom_pkg::coord_t     y_coord,
    input  elev_geom_pkg::sim_state_t sim_state,
    input  logic [7:0]                destination,
    output elev_color_pkg::channel_t  red,
    output elev_color_pkg::channel_t  green,
    output elev_color_pkg::channel_t  blue
);
    import elev_geom_pkg::*;
    import elev_color_pkg::*;

    region_t    s1_region;
    logic       s1_floor_odd;
    coord_t     s1_x;
    coord_t     s1_y;
    logic       s1_valid;
    sim_state_t sim_state_q;
    logic [7:0] destination_q;
    pix_class_t s2_class;
    logic       s2_valid;

    // Align state and destination with the pixel leaving stage one
    always_ff @(posedge clk) begin
        sim_state_q   <= sim_state;
        destination_q <= destination;
    end

    region_classify region_classify_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .x_coord   (x_coord),
        .y_coord   (y_coord),
        .region    (s1_region),
        .floor_odd (s1_floor_odd),
        .x_q       (s1_x),
        .y_q       (s1_y),
        .valid     (s1_valid)
    );

    car_locate car_locate_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .region      (s1_region),
        .floor_odd   (s1_floor_odd),
        .x_q         (s1_x),
        .y_q         (s1_y),
        .valid_in    (s1_valid),
        .sim_state   (sim_state_q),
        .destination (destination_q),
        .pix_class   (s2_class),
        .valid       (s2_valid)
    );

    palette_map palette_map_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_class (s2_class),
        .valid_in  (s2_valid),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// File: palette_map.sv
`timescale 1ns/1ns
`default_nettype none

module palette_map (
    input  logic                       clk,
    input  logic                       rst_n,
    input  elev_color_pkg::pix_class_t pix_class,
    input  logic                       valid_in,
    output elev_color_pkg::channel_t   red,
    output elev_color_pkg::channel_t   green,
    output elev_color_pkg::channel_t   blue
);
    import elev_color_pkg::*;

    channel_t red_d;
    channel_t green_d;
    channel_t blue_d;

    always_comb begin
        case (pix_class)
            pc_sky:       {red_d, green_d, blue_d} = {sky_r, sky_g, sky_b};
            pc_floor_a:   {red_d, green_d, blue_d} = {floor_a_r, floor_a_g, floor_a_b};
            pc_floor_b:   {red_d, green_d, blue_d} = {floor_b_r, floor_b_g, floor_b_b};
            pc_outline:   {red_d, green_d, blue_d} = {outline_r, outline_g, outline_b};
            pc_shaft_bg:  {red_d, green_d, blue_d} = {shaft_bg_r, shaft_bg_g, shaft_bg_b};
            pc_car:       {red_d, green_d, blue_d} = {car_r, car_g, car_b};
            pc_stop_bg:   {red_d, green_d, blue_d} = {stop_bg_r, stop_bg_g, stop_bg_b};
            pc_stop_mark: {red_d, green_d, blue_d} = {stop_mark_r, stop_mark_g, stop_mark_b};
            pc_grass:     {red_d, green_d, blue_d} = {grass_r, grass_g, grass_b};
            default:      {red_d, green_d, blue_d} = {blank_r, blank_g, blank_b};
        endcase
    end

    // Black during blanking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (!valid_in) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= red_d;
            green <= green_d;
            blue  <= blue_d;
        end
    end

endmodule

`default_nettype wire

// File: region_classify.sv
`timescale 1ns/1ns
`default_nettype none

module region_classify (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  elev_geom_pkg::coord_t  x_coord,
    input  elev_geom_pkg::coord_t  y_coord,
    output elev_geom_pkg::region_t region,
    output logic                   floor_odd,
    output elev_geom_pkg::coord_t  x_q,
    output elev_geom_pkg::coord_t  y_q,
    output logic                   valid
);
    import elev_geom_pkg::*;

    region_t region_d;
    coord_t  band_raw;
    logic [2:0] band;
    logic above_ground;
    logic in_building;
    logic in_outline;
    logic in_right_sky;

    // Floor band counted down from the top buffer, floor 1 absorbs the rest
    always_comb begin
        band_raw = (y_coord - coord_t'(top_bottom_buffer)) / coord_t'(floor_width);
        if (band_raw > 10'd5) begin
            band = 3'd5;
        end else begin
            band = band_raw[2:0];
        end
    end

    assign above_ground = y_coord < max_vert - top_bottom_buffer;

    assign in_right_sky = (x_coord >= max_horiz - side_buffer) && (x_coord < max_horiz)
        && above_ground;

    assign in_building = ((x_coord >= side_buffer) && (x_coord < building_left_end))
        || ((x_coord >= building_right_start) && (x_coord < max_horiz - side_buffer));

    assign in_outline = ((x_coord >= building_left_end) && (x_coord < shaft_left_start))
        || ((x_coord >= shaft_left_end) && (x_coord < shaft_right_start))
        || ((x_coord >= shaft_right_end) && (x_coord < building_right_start));

    // Priority follows the drawing order of the scene
    always_comb begin
        if ((x_coord < side_buffer) || (y_coord < top_bottom_buffer) || in_right_sky) begin
            region_d = reg_sky;
        end else if (in_building) begin
            region_d = reg_building;
        end else if (in_outline && above_ground) begin
            region_d = reg_outline;
        end else if ((x_coord >= shaft_left_start) && (x_coord < shaft_left_end)
                     && above_ground) begin
            region_d = reg_shaft_left;
        end else if ((x_coord >= shaft_right_start) && (x_coord < shaft_right_end)
                     && above_ground) begin
            region_d = reg_shaft_right;
        end else begin
            region_d = reg_grass;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            region    <= reg_grass;
            floor_odd <= 1'b0;
        end else begin
            valid     <= enable;
            region    <= region_d;
            floor_odd <= band[0];
        end
    end

    // Coordinates ride along for the car test in the next stage
    always_ff @(posedge clk) begin
        x_q <= x_coord;
        y_q <= y_coord;
    end

endmodule

`default_nettype wire

// File: tb.f
elev_geom_pkg.sv
elev_color_pkg.sv
region_classify.sv
car_locate.sv
palette_map.sv
elev_pixel_pipe.sv
elev_pixel_assert.sv
tb_elev_pixel.sv

// File: tb_elev_pixel.sv
`timescale 1ns/1ns

module tb_elev_pixel;
    import elev_geom_pkg::*;
    import elev_color_pkg::*;

    localparam int clk_period = 4;
    // Pixels driven by the tests and the flush
    localparam int test_cycles = 24 + 24 + 172 + 96 + 32 + 300 + 3;
    localparam int watchdog_cycles = test_cycles + 100;

    logic       clk;
    logic       rst_n;
    logic       enable;
    coord_t     x_coord;
    coord_t     y_coord;
    sim_state_t sim_state;
    logic [7:0] destination;
    channel_t   red;
    channel_t   green;
    channel_t   blue;

    logic [11:0] exp_q [$];
    string       name_q [$];
    logic [11:0] want;
    logic [11:0] got;
    string       tname;
    logic [15:0] lfsr = 16'd40;

    elev_pixel_pipe dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .sim_state   (sim_state),
        .destination (destination),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on first error");
    endtask

    function automatic int car_top(input int lvl);
        int capped;
        capped = (lvl > 10) ? 10 : lvl;
        return 390 - (75 * capped) / 2;
    endfunction

    // Expected {r, g, b} from the scene rules in drawing order
    function automatic logic [11:0] model_rgb(input int x, input int y, input int st,
                                              input int dest);
        int band;
        int top;
        if (x < 20 || y < 15 || (x >= 620 && x <= 639 && y < 465)) return 12'h28f;
        if ((x >= 20 && x <= 194) || (x >= 405 && x <= 619)) begin
            band = (y - 15) / 75;
            if (band > 5) band = 5;
            return (band % 2) ? 12'hbbb : 12'h9aa;
        end
        if (y >= 465) return 12'h0f0;
        if ((x >= 195 && x <= 204) || (x >= 295 && x <= 304) || (x >= 395 && x <= 404))
            return 12'h000;
        if (x < 205 || x > 394) return 12'h0f0;
        top = car_top((x <= 294) ? (dest >> 4) & 15 : dest & 15);
        if (st == 0) return (y >= 395) ? 12'h444 : 12'h841;
        if (st == 1) return (y >= top && y < top + 75) ? 12'h444 : 12'h841;
        return (x >= 300 && x <= 339 && y >= 200 && y <= 259) ? 12'hf00 : 12'h000;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    task automatic drive_pixel(input string name, input logic en, input int x, input int y,
                               input int st, input int dest);
        @(posedge clk);
        enable <= en;
        x_coord <= coord_t'(x);
        y_coord <= coord_t'(y);
        sim_state <= sim_state_t'(st);
        destination <= 8'(dest);
        exp_q.push_back(en ? model_rgb(x, y, st, dest) : 12'h000);
        name_q.push_back(name);
    endtask

    // Colour of a pixel shows at the fourth falling edge after it is driven
    always @(negedge clk) begin
        if (exp_q.size() > 3) begin
            want = exp_q.pop_front();
            tname = name_q.pop_front();
            got = {red, green, blue};
            assert (got === want) else abort_run($sformatf(
                "MISMATCH test=%s expected=%03h actual=%03h", tname, want, got));
        end
    end

    task automatic mix_blanked_pixels();
        for (int i = 0; i < 24; i++) begin
            drive_pixel("reset_blank", (i % 3) != 1, i * 26, i * 19, 0, 0);
        end
    endtask

    task automatic probe_scenery();
        int sx [24] = '{10, 300, 630, 10, 100, 100, 100, 100, 100, 100, 100,
                        500, 500, 500, 500, 500, 500, 200, 300, 400, 250, 350, 630, 300};
        int sy [24] = '{100, 5, 200, 470, 45, 120, 195, 270, 345, 420, 475,
                        89, 164, 239, 314, 389, 464, 100, 100, 100, 470, 470, 470, 470};
        for (int i = 0; i < 24; i++) begin
            drive_pixel("scenery", 1'b1, sx[i], sy[i], 0, 8'h37);
        end
    endtask

    task automatic sweep_idle_cars();
        for (int y = 385; y <= 470; y++) begin
            drive_pixel("idle_cars", 1'b1, 250, y, 0, 8'h5a);
            drive_pixel("idle_cars", 1'b1, 350, y, 0, 8'h5a);
        end
    endtask

    task automatic check_car_rows(input int x, input int top, input int dest);
        drive_pixel("moving_cars", 1'b1, x, top - 1, 1, dest);
        drive_pixel("moving_cars", 1'b1, x, top, 1, dest);
        drive_pixel("moving_cars", 1'b1, x, top + 74, 1, dest);
        drive_pixel("moving_cars", 1'b1, x, top + 75, 1, dest);
    endtask

    task automatic step_car_levels();
        int levels [12] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 15};
        int left_lvl;
        int right_lvl;
        for (int j = 0; j < 12; j++) begin
            left_lvl = levels[j];
            right_lvl = levels[(j + 5) % 12];
            check_car_rows(250, car_top(left_lvl), (left_lvl << 4) | right_lvl);
            check_car_rows(350, car_top(right_lvl), (left_lvl << 4) | right_lvl);
        end
    endtask

    task automatic scan_stop_marker();
        int xs [8] = '{210, 250, 294, 305, 320, 339, 340, 394};
        int ys [4] = '{199, 200, 259, 260};
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                drive_pixel("stop", 1'b1, xs[i], ys[k], (k % 2) ? 3 : 2, 8'ha3);
            end
        end
    endtask

    task automatic stream_random_pixels();
        int x;
        int y;
        int st;
        int dest;
        for (int i = 0; i < 300; i++) begin
            take_bits(10, x);
            take_bits(10, y);
            take_bits(2, st);
            take_bits(8, dest);
            drive_pixel("stream", 1'b1, x % 640, y % 480, st, dest);
        end
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run("Timeout: the tests did not finish in the expected number of cycles");
    end

    initial begin
        rst_n = 1'b0;
        enable = 1'b0;
        x_coord = '0;
        y_coord = '0;
        sim_state = '0;
        destination = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert ({red, green, blue} === 12'h000) else abort_run($sformatf(
            "MISMATCH test=reset expected=000 actual=%03h", {red, green, blue}));
        mix_blanked_pixels();
        probe_scenery();
        sweep_idle_cars();
        step_car_levels();
        scan_stop_marker();
        stream_random_pixels();
        repeat (3) drive_pixel("flush", 1'b0, 0, 0, 0, 0);
        @(posedge clk);
        if (dut_i.pipe_checks_i.failures == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("A bound assertion reported an error");
        end
    end

endmodule
